// ==== Bender.yml ====
package:
  name: kd_tree

sources:
  # Design, in compile order
  - files:
      - design/kd_pkg.sv
      - design/node_write_decoder.sv
      - design/kd_internal_node.sv
      - design/kd_tree_level.sv
      - design/leaf_encoder.sv
      - design/kd_tree_top.sv

  # Testbench, top module kd_tree_tb
  - target: test
    include_dirs:
      - bench
    files:
      - bench/kd_tree_tb.sv

// ==== bench/kd_tree_model.svh ====
`ifndef KD_TREE_MODEL_SVH
`define KD_TREE_MODEL_SVH

// Mirror of the node words, index n is breadth-first node n
kd_pkg::node_word_t tree_nodes [kd_pkg::NUM_NODES];
int unsigned        load_addr; // Node the next real write lands in

// Matches the DUT state after reset
function automatic void clear_tree();
  for (int n = 0; n < kd_pkg::NUM_NODES; n++) begin
    tree_nodes[n] = '0;
  end
  load_addr = 0;
endfunction

// Called only for writes with both enables high
function automatic void store_node_word(input kd_pkg::node_word_t w);
  tree_nodes[load_addr] = w;
  load_addr = (load_addr + 1) % kd_pkg::NUM_NODES; // Wraps after node 126
endfunction

// comp0 is the lowest field of the patch
function automatic kd_pkg::comp_t select_component(input kd_pkg::patch_t p,
                                                   input kd_pkg::dim_t d);
  if (d >= kd_pkg::NUM_DIMS) begin
    return '0;
  end
  return p[d*kd_pkg::COMP_WIDTH +: kd_pkg::COMP_WIDTH];
endfunction

// Walk from the root, children of node n are 2n+1 and 2n+2
function automatic kd_pkg::leaf_idx_t walk_tree(input kd_pkg::patch_t p);
  int unsigned        n;
  kd_pkg::node_word_t w;
  n = 0;
  for (int lvl = 0; lvl < kd_pkg::TREE_DEPTH; lvl++) begin
    w = tree_nodes[n];
    if (w.dim >= kd_pkg::NUM_DIMS) begin
      n = 2*n + 1;                                   // Out-of-range dim goes left
    end else if (select_component(p, w.dim) < w.threshold) begin
      n = 2*n + 1;                                   // Strictly less goes left
    end else begin
      n = 2*n + 2;                                   // Equal or greater goes right
    end
  end
  return kd_pkg::leaf_idx_t'(n - kd_pkg::NUM_NODES); // Leaves follow the last node
endfunction

`endif

// ==== bench/kd_tree_tb.sv ====
`timescale 1ns/1ns

module kd_tree_tb;

  // One query in flight
  typedef struct packed {
    kd_pkg::leaf_idx_t leaf;  // Leaf the result must name
    int unsigned       issue; // Cycle in which query_valid was high
  } expect_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               fsm_enable;
  logic               sender_enable;
  kd_pkg::node_word_t sender_data;
  logic               query_valid;
  kd_pkg::patch_t     patch_in;
  kd_pkg::leaf_idx_t  leaf_index;
  logic               leaf_valid;

  expect_t           exp_q [$];           // Oldest query first
  logic              exp_valid = 1'b0;    // Expected leaf_valid after each edge
  kd_pkg::leaf_idx_t exp_index = '0;
  int unsigned       edge_no = 0;         // Rising edges so far
  int unsigned       pulse_count = 0;     // leaf_valid pulses seen
  int unsigned       pulse_base = 0;
  int                seed = 82156;

  kd_pkg::patch_t    saved_patch [8];     // Replayed across stray writes
  kd_pkg::leaf_idx_t saved_leaf [8];
  kd_pkg::patch_t    dir_patch;           // Query that the directed tree is built around

  `include "kd_tree_model.svh"

  kd_tree_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .sender_data   (sender_data),
    .query_valid   (query_valid),
    .patch_in      (patch_in),
    .leaf_index    (leaf_index),
    .leaf_valid    (leaf_valid)
  );

  always #50 clk = ~clk; // 100 ns period

  // Expected output per cycle
  // A query high in cycle c gives its result in cycle c + 8
  always @(posedge clk) begin
    edge_no = edge_no + 1;
    if (!rst_n) begin
      exp_valid <= 1'b0;
    end else if (exp_q.size() != 0 && exp_q[0].issue + 8 == edge_no) begin
      exp_valid <= 1'b1;
      exp_index <= exp_q[0].leaf;
      void'(exp_q.pop_front());
    end else begin
      exp_valid <= 1'b0; // Gap in the input stream
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && leaf_valid === 1'b1) begin
      pulse_count++;
    end
  end

  valid_check: assert property (@(posedge clk) disable iff (!rst_n) leaf_valid == exp_valid)
    else report_mismatch($sformatf("leaf_valid is %b, expected %b",
                                   $sampled(leaf_valid), $sampled(exp_valid)));

  index_check: assert property (@(posedge clk) disable iff (!rst_n)
                                exp_valid |-> leaf_index == exp_index)
    else report_mismatch($sformatf("leaf_index is %0d, expected %0d",
                                   $sampled(leaf_index), $sampled(exp_index)));

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string msg);
    fail_now($sformatf("ERROR at %0t ns: %s", $time, msg));
  endtask

  task automatic tick();
    @(posedge clk);
    #1; // Inputs change just after the edge
  endtask

  task automatic idle(input int cycles);
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
    query_valid   = 1'b0;
    repeat (cycles) tick();
  endtask

  task automatic write_word(input kd_pkg::node_word_t w);
    fsm_enable    = 1'b1;
    sender_enable = 1'b1;
    sender_data   = w;
    store_node_word(w);
    tick();
  endtask

  task automatic issue_query(input kd_pkg::patch_t p, input kd_pkg::leaf_idx_t leaf);
    expect_t e;
    e.leaf      = leaf;
    e.issue     = edge_no; // Edge count at the start of this cycle
    query_valid = 1'b1;
    patch_in    = p;
    exp_q.push_back(e);
    tick();
  endtask

  task automatic send_query(input kd_pkg::patch_t p);
    issue_query(p, walk_tree(p));
  endtask

  function automatic kd_pkg::patch_t random_patch();
    kd_pkg::patch_t p;
    p.comp0 = kd_pkg::comp_t'($random(seed));
    p.comp1 = kd_pkg::comp_t'($random(seed));
    p.comp2 = kd_pkg::comp_t'($random(seed));
    p.comp3 = kd_pkg::comp_t'($random(seed));
    p.comp4 = kd_pkg::comp_t'($random(seed));
    return p;
  endfunction

  function automatic kd_pkg::node_word_t random_word();
    kd_pkg::node_word_t w;
    w.dim       = kd_pkg::dim_t'($random(seed)); // Dims 5 to 7 appear now and then
    w.threshold = kd_pkg::comp_t'($random(seed));
    return w;
  endfunction

  // Every component moved by the same amount
  function automatic kd_pkg::patch_t offset_patch(input kd_pkg::patch_t p, input int delta);
    kd_pkg::patch_t q;
    q.comp0 = kd_pkg::comp_t'(int'(p.comp0) + delta);
    q.comp1 = kd_pkg::comp_t'(int'(p.comp1) + delta);
    q.comp2 = kd_pkg::comp_t'(int'(p.comp2) + delta);
    q.comp3 = kd_pkg::comp_t'(int'(p.comp3) + delta);
    q.comp4 = kd_pkg::comp_t'(int'(p.comp4) + delta);
    return q;
  endfunction

  task automatic load_random_tree();
    for (int n = 0; n < kd_pkg::NUM_NODES; n++) begin
      write_word(random_word());
    end
    idle(1);
  endtask

  // Node n compares dim n % 8
  // In-range thresholds equal the directed query
  task automatic load_directed_tree();
    kd_pkg::node_word_t w;
    for (int n = 0; n < kd_pkg::NUM_NODES; n++) begin
      w.dim = kd_pkg::dim_t'(n % 8);
      if (n % 8 < kd_pkg::NUM_DIMS) begin
        w.threshold = select_component(dir_patch, w.dim);
      end else begin
        w.threshold = '0; // A used compare would send right here
      end
      write_word(w);
    end
    idle(1);
  endtask

  // Only one enable high at a time so nothing gets written
  task automatic stray_writes(input int cycles);
    repeat (cycles) begin
      fsm_enable    = 1'b1;
      sender_enable = 1'b0;
      sender_data   = random_word();
      tick();
    end
    repeat (cycles) begin
      fsm_enable    = 1'b0;
      sender_enable = 1'b1;
      sender_data   = random_word();
      tick();
    end
    idle(1);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < 40) begin // At most 8 in flight
      tick();
      cnt++;
    end
    if (exp_q.size() != 0) begin
      fail_now($sformatf("Timed out after %0d cycles with %0d results still outstanding",
                         cnt, exp_q.size()));
    end
    tick(); // Last pulse reaches the negedge counter
  endtask

  task automatic check_pulses(input int unsigned expected);
    assert (pulse_count - pulse_base == expected)
      else report_mismatch($sformatf("%0d leaf_valid pulses, expected %0d",
                                     pulse_count - pulse_base, expected));
    pulse_base = pulse_count;
  endtask

  initial begin
    rst_n         = 1'b0;
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
    sender_data   = '0;
    query_valid   = 1'b0;
    patch_in      = '0;
    dir_patch.comp0 = kd_pkg::comp_t'(100);
    dir_patch.comp1 = kd_pkg::comp_t'(200);
    dir_patch.comp2 = kd_pkg::comp_t'(300);
    dir_patch.comp3 = kd_pkg::comp_t'(400);
    dir_patch.comp4 = kd_pkg::comp_t'(500);
    clear_tree();
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    idle(12); // Quiet output after reset
    check_pulses(0);

    // Random tree with one query in flight at a time
    load_random_tree();
    for (int i = 0; i < 12; i++) begin
      send_query(random_patch());
      idle(10);
    end
    wait_drain();
    check_pulses(12);

    // Back-to-back stream of 64 with one gap
    for (int i = 0; i < 64; i++) begin
      send_query(random_patch());
      if (i == 39) begin
        idle(3);
      end
    end
    idle(1);
    wait_drain();
    check_pulses(64);

    // Directed tree where the hand-traced path 0 2 6 13 27 56 114 ends at leaf 103
    load_directed_tree();
    issue_query(dir_patch, kd_pkg::leaf_idx_t'(103));
    issue_query(offset_patch(dir_patch, -1), kd_pkg::leaf_idx_t'(0));   // All left
    issue_query(offset_patch(dir_patch, 1), kd_pkg::leaf_idx_t'(103));  // Same as equal
    for (int i = 0; i < 16; i++) begin
      send_query(random_patch());
    end
    idle(1);
    wait_drain();
    check_pulses(19);

    // Single-enable writes leave the tree and the address alone
    for (int i = 0; i < 8; i++) begin
      saved_patch[i] = random_patch();
      saved_leaf[i]  = walk_tree(saved_patch[i]);
    end
    stray_writes(20);
    for (int i = 0; i < 8; i++) begin
      issue_query(saved_patch[i], saved_leaf[i]);
    end
    idle(1);
    wait_drain();
    check_pulses(8);

    // 127 more writes wrap the address again
    load_random_tree();
    for (int i = 0; i < 8; i++) begin
      send_query(saved_patch[i]);
    end
    for (int i = 0; i < 8; i++) begin
      send_query(random_patch());
    end
    idle(1);
    wait_drain();
    check_pulses(16);

    idle(4);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== design/kd_internal_node.sv ====
`timescale 1ns/1ns

module kd_internal_node (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we,       // Already qualified with this node's select
  input  kd_pkg::node_word_t wdata,
  input  logic               valid_in, // Patch has reached this node
  input  kd_pkg::patch_t     patch,
  output logic               valid_left,
  output logic               valid_right
);

  kd_pkg::node_word_t word; // Stored dimension and threshold
  kd_pkg::comp_t      comp; // Component named by word.dim
  logic               dim_ok;
  logic               go_left;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word <= '0;
    end else if (we) begin
      word <= wdata; // Used from the next edge on
    end
  end

  // Component select
  always_comb begin
    case (word.dim)
      kd_pkg::dim_t'(0): comp = patch.comp0;
      kd_pkg::dim_t'(1): comp = patch.comp1;
      kd_pkg::dim_t'(2): comp = patch.comp2;
      kd_pkg::dim_t'(3): comp = patch.comp3;
      kd_pkg::dim_t'(4): comp = patch.comp4;
      default:           comp = patch.comp0; // Ignored, dim_ok is low
    endcase
  end

  assign dim_ok  = (word.dim < kd_pkg::dim_t'(kd_pkg::NUM_DIMS));
  assign go_left = !dim_ok || (comp < word.threshold); // Equal goes right

  // Only the active node drives a child
  assign valid_left  = valid_in & go_left;
  assign valid_right = valid_in & ~go_left;

endmodule

// ==== design/kd_pkg.sv ====
package kd_pkg;

  // Patch geometry
  localparam int NUM_DIMS   = 5;  // Components per patch
  localparam int COMP_WIDTH = 11; // Bits per component and threshold
  localparam int DIM_WIDTH  = 3;  // Bits of the dimension select

  // Tree shape
  localparam int TREE_DEPTH = 7;                  // Internal levels
  localparam int NUM_NODES  = (1 << TREE_DEPTH) - 1; // Internal nodes, breadth-first
  localparam int NUM_LEAVES = 1 << TREE_DEPTH;     // Leaves below the last level
  localparam int LEAF_WIDTH = TREE_DEPTH;          // Bits of a leaf index

  // One patch component or one node threshold
  typedef logic [COMP_WIDTH-1:0] comp_t;

  // Dimension index, values 5 to 7 are out of range
  typedef logic [DIM_WIDTH-1:0] dim_t;

  typedef logic [LEAF_WIDTH-1:0] leaf_idx_t; // Leaf number, 0 is the leftmost leaf

  // One-hot write select, bit n is breadth-first node n
  typedef logic [NUM_NODES-1:0] node_sel_t;

  // Query patch, comp0 sits in the low bits
  typedef struct packed {
    comp_t comp4;
    comp_t comp3;
    comp_t comp2;
    comp_t comp1;
    comp_t comp0;
  } patch_t;

  // Word stored in each internal node
  typedef struct packed {
    dim_t  dim;       // Component to compare
    comp_t threshold; // Split value, less goes left
  } node_word_t;

endpackage

// ==== design/kd_tree_level.sv ====
`timescale 1ns/1ns

module kd_tree_level #(
  parameter int LEVEL = 0 // Depth in the tree, level L holds 2^L nodes
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     node_we,
  input  logic [2**LEVEL-1:0]      node_sel_slice, // Select bits of this level's nodes
  input  kd_pkg::node_word_t       wdata,
  input  logic [2**LEVEL-1:0]      valid_in,       // One-hot, bit p is node p
  input  kd_pkg::patch_t           patch_in,
  output logic [2**(LEVEL+1)-1:0]  valid_out,      // Registered child valids
  output kd_pkg::patch_t           patch_out
);

  // Child valids before the pipeline register
  // Bit 2p is the left child of node p and 2p+1 its right child
  logic [2**(LEVEL+1)-1:0] child_valid;

  for (genvar p = 0; p < 2**LEVEL; p++) begin : g_node
    kd_internal_node u_node (
      .clk         (clk),
      .rst_n       (rst_n),
      .we          (node_we & node_sel_slice[p]),
      .wdata       (wdata),                // Shared load bus
      .valid_in    (valid_in[p]),
      .patch       (patch_in),
      .valid_left  (child_valid[2*p]),
      .valid_right (child_valid[2*p+1])
    );
  end

  // Level register for the valid vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= '0;
    end else begin
      valid_out <= child_valid;
    end
  end

  // Patch moves along with its valid, qualified only by valid_out
  always_ff @(posedge clk) begin
    patch_out <= patch_in;
  end

endmodule

// ==== design/kd_tree_top.sv ====
`timescale 1ns/1ns

module kd_tree_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fsm_enable,
  input  logic               sender_enable,
  input  kd_pkg::node_word_t sender_data,  // Node word, breadth-first order
  input  logic               query_valid,  // One patch per strobe
  input  kd_pkg::patch_t     patch_in,
  output kd_pkg::leaf_idx_t  leaf_index,
  output logic               leaf_valid    // 8 cycles after query_valid
);

  logic              node_we;
  kd_pkg::node_sel_t node_sel;

  // Valid vectors of all levels in heap order
  // Level L input sits at [2^L-1 +: 2^L], the leaf vector at [127 +: 128]
  wire [2*kd_pkg::NUM_LEAVES-2:0] valid_chain;

  // Patch entering each level, the last entry is the patch beside the leaf vector
  wire kd_pkg::patch_t patch_chain [kd_pkg::TREE_DEPTH+1];

  assign valid_chain[0] = query_valid; // Root level sees the strobe unregistered
  assign patch_chain[0] = patch_in;

  // Decode stage, write address and node select
  node_write_decoder u_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .node_we       (node_we),
    .node_sel      (node_sel)
  );

  // Execute stage, seven registered levels
  for (genvar l = 0; l < kd_pkg::TREE_DEPTH; l++) begin : g_level
    kd_tree_level #(
      .LEVEL (l)
    ) u_level (
      .clk            (clk),
      .rst_n          (rst_n),
      .node_we        (node_we),
      .node_sel_slice (node_sel[2**l-1 +: 2**l]), // Same heap slice as the valids
      .wdata          (sender_data),
      .valid_in       (valid_chain[2**l-1 +: 2**l]),
      .patch_in       (patch_chain[l]),
      .valid_out      (valid_chain[2**(l+1)-1 +: 2**(l+1)]),
      .patch_out      (patch_chain[l+1])
    );
  end

  // Result stage
  leaf_encoder u_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .leaf_vec   (valid_chain[kd_pkg::NUM_LEAVES-1 +: kd_pkg::NUM_LEAVES]),
    .leaf_index (leaf_index),
    .leaf_valid (leaf_valid)
  );

endmodule

// ==== design/leaf_encoder.sv ====
`timescale 1ns/1ns

module leaf_encoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [kd_pkg::NUM_LEAVES-1:0] leaf_vec,   // One-hot from the last level
  output kd_pkg::leaf_idx_t             leaf_index,
  output logic                          leaf_valid
);

  kd_pkg::leaf_idx_t idx; // Encoded position of the set bit
  logic              any;

  // Priority scan
  // Later iterations override, so the highest set bit wins
  always_comb begin
    idx = '0;
    for (int i = 0; i < kd_pkg::NUM_LEAVES; i++) begin
      if (leaf_vec[i]) begin
        idx = kd_pkg::leaf_idx_t'(i);
      end
    end
  end

  assign any = |leaf_vec; // At most one bit in normal use

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leaf_index <= '0;
      leaf_valid <= 1'b0;
    end else begin
      leaf_index <= idx;
      leaf_valid <= any; // Single-cycle pulse per query
    end
  end

endmodule

// ==== design/node_write_decoder.sv ====
`timescale 1ns/1ns

module node_write_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fsm_enable,    // Host is in the load phase
  input  logic              sender_enable, // Word on the bus this cycle
  output logic              node_we,
  output kd_pkg::node_sel_t node_sel
);

  // Write address, one node per write in breadth-first order
  logic [kd_pkg::TREE_DEPTH-1:0] wr_addr;
  logic                          last_node;

  assign node_we   = fsm_enable & sender_enable; // Both strobes needed
  assign last_node = (wr_addr == kd_pkg::TREE_DEPTH'(kd_pkg::NUM_NODES - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (node_we) begin
      if (last_node) begin
        wr_addr <= '0; // Wrap after node 126 so a new tree can follow
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // 7 to 127 decode
  // Address 127 never occurs, so the shifted-out bit is never needed
  always_comb begin
    node_sel = kd_pkg::node_sel_t'(1) << wr_addr;
  end

endmodule

// ==== kd_tree_top.f ====
+incdir+bench
design/kd_pkg.sv
design/node_write_decoder.sv
design/kd_internal_node.sv
design/kd_tree_level.sv
design/leaf_encoder.sv
design/kd_tree_top.sv
bench/kd_tree_tb.sv
